// File: verilog/board_ctl_pkg.sv
`default_nettype none

package board_ctl_pkg;

	// ----------------------------------------------------------
	// register map, 6-bit word addresses
	// ----------------------------------------------------------
	typedef enum logic [5:0] {
		REG_PWMC = 6'd2, // fan duty, write only
		REG_WDG  = 6'd3,
		REG_SFT  = 6'd4,
		REG_FAN0 = 6'd5, // read only
		REG_FAN1 = 6'd6, // read only
		REG_TIME = 6'd7
	} reg_addr_e;

	// shift register commands, data bits 1:0 of an SFT write
	typedef enum logic [1:0] {
		SFT_MASTER_RESET  = 2'd0,
		SFT_SHIFT_BYTE    = 2'd1,
		SFT_STORE         = 2'd2,
		SFT_OUTPUT_ENABLE = 2'd3
	} shift_cmd_e;

	// ----------------------------------------------------------
	// window and field widths
	// ----------------------------------------------------------
	localparam int TICK_CYCLES = 100; // one measurement window
	localparam int TICK_W      = $clog2(TICK_CYCLES);
	localparam int PWM_W       = 10;
	localparam int CNT_W       = 26; // watchdog and fan counts
	localparam int TIM_W       = 6;

endpackage

`default_nettype wire

// File: verilog/shift_driver.sv
`timescale 1ns/1ps
`default_nettype none

module shift_driver import board_ctl_pkg::*; (
	input  wire logic       CLK_I,
	input  wire logic       RST_I,
	input  wire logic       start,
	input  wire shift_cmd_e cmd,
	input  wire logic       oen_bit,
	input  wire logic [7:0] din,
	output logic            done,
	output logic            shcp,
	output logic            ds,
	output logic            stcp,
	output logic            mr_n,
	output logic            oe_n
);

	typedef enum logic [1:0] {
		IDLE,
		SHIFT,
		RESET_LOW,
		STORE_PULSE
	} state_e;

	state_e     state;
	logic [3:0] bit_cnt; // bit index in [3:1], clock phase in [0]
	logic [7:0] sreg;

	// ----------------------------------------------------------
	// sequencer
	// ----------------------------------------------------------
	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			state   <= IDLE;
			bit_cnt <= '0;
			done    <= 1'b0;
			shcp    <= 1'b0;
			ds      <= 1'b0;
			stcp    <= 1'b0;
			mr_n    <= 1'b1;
			oe_n    <= 1'b1;
		end else begin
			done <= 1'b0;
			case (state)
				IDLE: begin
					bit_cnt <= '0;
					if (start) begin
						case (cmd)
							SFT_MASTER_RESET: begin
								mr_n  <= 1'b0;
								state <= RESET_LOW;
							end
							SFT_SHIFT_BYTE: begin
								ds    <= din[7]; // MSB goes out first
								state <= SHIFT;
							end
							SFT_STORE: begin
								stcp  <= 1'b1;
								state <= STORE_PULSE;
							end
							SFT_OUTPUT_ENABLE: begin
								oe_n <= oen_bit;
								done <= 1'b1;
							end
						endcase
					end
				end
				SHIFT: begin
					bit_cnt <= bit_cnt + 4'd1;
					if (!bit_cnt[0]) begin
						shcp <= 1'b1; // data settled, clock it in
					end else begin
						shcp <= 1'b0;
						if (bit_cnt == 4'd15) begin
							ds    <= 1'b0;
							done  <= 1'b1;
							state <= IDLE;
						end else begin
							ds <= sreg[6];
						end
					end
				end
				RESET_LOW: begin
					bit_cnt <= bit_cnt + 4'd1;
					if (bit_cnt == 4'd1) begin // low for two cycles
						mr_n  <= 1'b1;
						done  <= 1'b1;
						state <= IDLE;
					end
				end
				STORE_PULSE: begin
					stcp  <= 1'b0;
					done  <= 1'b1;
					state <= IDLE;
				end
			endcase
		end
	end

	// data byte, moves up one place after each shcp high cycle
	always_ff @(posedge CLK_I) begin
		if (state == IDLE && start && cmd == SFT_SHIFT_BYTE)
			sreg <= din;
		else if (state == SHIFT && bit_cnt[0])
			sreg <= {sreg[6:0], 1'b0};
	end

endmodule

`default_nettype wire

// File: verilog/fan_tach.sv
`timescale 1ns/1ps
`default_nettype none

module fan_tach import board_ctl_pkg::*; (
	input  wire logic             CLK_I,
	input  wire logic             RST_I,
	input  wire logic             tick,
	input  wire logic             fan_in,
	output logic      [CNT_W-1:0] rate
);

	logic [2:0]       fan_sync;
	logic             fan_fall;
	logic [CNT_W-1:0] edge_cnt;

	// ----------------------------------------------------------
	// synchroniser and falling edge
	// ----------------------------------------------------------
	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I)
			fan_sync <= '0;
		else
			fan_sync <= {fan_sync[1:0], fan_in};
	end

	assign fan_fall = fan_sync[2] & ~fan_sync[1];

	// count edges over one window, then latch the result
	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			edge_cnt <= '0;
			rate     <= '0;
		end else if (tick) begin
			rate     <= edge_cnt;
			edge_cnt <= CNT_W'(fan_fall); // edge on the tick starts the next window
		end else if (fan_fall) begin
			edge_cnt <= edge_cnt + CNT_W'(1);
		end
	end

endmodule

`default_nettype wire

// File: verilog/countdown_timer.sv
`timescale 1ns/1ps
`default_nettype none

module countdown_timer import board_ctl_pkg::*; (
	input  wire logic             CLK_I,
	input  wire logic             RST_I,
	input  wire logic             tick,
	input  wire logic             load,
	input  wire logic             load_en,
	input  wire logic             mask_in,
	input  wire logic [TIM_W-1:0] count_in,
	output logic      [TIM_W-1:0] count,
	output logic                  mask,
	output logic                  irq
);

	// ----------------------------------------------------------
	// count in whole windows
	// ----------------------------------------------------------
	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			count <= '0;
			mask  <= 1'b1; // masked out of reset
		end else begin
			if (load)
				mask <= mask_in;
			// a load write wins over a tick in the same cycle
			if (load && load_en)
				count <= count_in;
			else if (tick && count != '0)
				count <= count - TIM_W'(1);
		end
	end

	// level, held until reloaded or masked
	assign irq = ~mask & (count == '0);

endmodule

`default_nettype wire

// File: verilog/board_ctl.sv
`timescale 1ns/1ps
`default_nettype none

module board_ctl import board_ctl_pkg::*; (
	input  wire logic        CLK_I,
	input  wire logic        RST_I,
	// bus slave
	input  wire logic        stb,
	input  wire logic        we,
	input  wire logic [5:0]  adr,
	input  wire logic [31:0] dat_i,
	output logic      [31:0] dat_o,
	output logic             ack,
	// fan drive and watchdog
	output logic             pwm,
	output logic             watch_dog,
	// 74HC595 pins
	output logic             sft_shcp,
	output logic             sft_ds,
	output logic             sft_stcp,
	output logic             sft_mr_n,
	output logic             sft_oe_n,
	// tachometers and timers
	input  wire logic        fan_in0,
	input  wire logic        fan_in1,
	output logic             time0_int,
	output logic             time1_int
);

	// ----------------------------------------------------------
	// bus acknowledge and decode
	// ----------------------------------------------------------
	logic access;
	logic wr_strobe;
	logic rd_strobe;

	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I)
			ack <= 1'b0;
		else
			ack <= stb & ~ack; // one cycle, then drop
	end

	assign access    = stb & ~ack;
	assign wr_strobe = access & we;
	assign rd_strobe = access & ~we;

	logic pwm_wr, wdg_wr, sft_wr, time_wr;

	assign pwm_wr  = wr_strobe & (adr == REG_PWMC);
	assign wdg_wr  = wr_strobe & (adr == REG_WDG);
	assign sft_wr  = wr_strobe & (adr == REG_SFT);
	assign time_wr = wr_strobe & (adr == REG_TIME);

	// ----------------------------------------------------------
	// PWM
	// ----------------------------------------------------------
	logic [PWM_W-1:0] pwm_duty;
	logic [PWM_W-1:0] pwm_cnt;

	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			pwm_duty <= '0;
			pwm_cnt  <= '0;
		end else begin
			pwm_cnt <= pwm_cnt + PWM_W'(1); // free running, 1024 period
			if (pwm_wr)
				pwm_duty <= dat_i[PWM_W-1:0];
		end
	end

	assign pwm = pwm_cnt < pwm_duty;

	// ----------------------------------------------------------
	// watchdog
	// ----------------------------------------------------------
	logic             wdg_en;
	logic [CNT_W-1:0] wdg_cnt;

	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			wdg_en  <= 1'b0;
			wdg_cnt <= '0;
		end else begin
			if (wdg_wr)
				wdg_en <= dat_i[0];
			// load only when already running or being switched on
			if (wdg_wr && (wdg_en || dat_i[0]))
				wdg_cnt <= dat_i[CNT_W:1];
			else if (wdg_cnt != '0)
				wdg_cnt <= wdg_cnt - CNT_W'(1);
		end
	end

	assign watch_dog = wdg_en && (wdg_cnt == CNT_W'(1) || wdg_cnt == CNT_W'(2));

	// ----------------------------------------------------------
	// window tick
	// ----------------------------------------------------------
	logic [TICK_W-1:0] tick_cnt;
	logic              tick;

	assign tick = (tick_cnt == TICK_W'(TICK_CYCLES - 1));

	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I)
			tick_cnt <= '0;
		else if (tick)
			tick_cnt <= '0;
		else
			tick_cnt <= tick_cnt + TICK_W'(1);
	end

	// ----------------------------------------------------------
	// shift register driver
	// ----------------------------------------------------------
	logic sft_done;
	logic sft_done_r; // sticky until next SFT write

	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I)
			sft_done_r <= 1'b0;
		else if (sft_wr)
			sft_done_r <= 1'b0;
		else if (sft_done)
			sft_done_r <= 1'b1;
	end

	shift_driver u_shift (
		.CLK_I   (CLK_I),
		.RST_I   (RST_I),
		.start   (sft_wr),
		.cmd     (shift_cmd_e'(dat_i[1:0])),
		.oen_bit (dat_i[2]),
		.din     (dat_i[15:8]),
		.done    (sft_done),
		.shcp    (sft_shcp),
		.ds      (sft_ds),
		.stcp    (sft_stcp),
		.mr_n    (sft_mr_n),
		.oe_n    (sft_oe_n)
	);

	// tachometers
	logic [CNT_W-1:0] fan_rate0, fan_rate1;

	fan_tach u_fan0 (.CLK_I(CLK_I), .RST_I(RST_I), .tick(tick), .fan_in(fan_in0), .rate(fan_rate0));
	fan_tach u_fan1 (.CLK_I(CLK_I), .RST_I(RST_I), .tick(tick), .fan_in(fan_in1), .rate(fan_rate1));

	// timers, channel 0 in the low half, channel 1 in the high half
	logic [TIM_W-1:0] tim_cnt0, tim_cnt1;
	logic             tim_mask0, tim_mask1;

	countdown_timer u_tim0 (
		.CLK_I    (CLK_I),
		.RST_I    (RST_I),
		.tick     (tick),
		.load     (time_wr),
		.load_en  (dat_i[0]),
		.mask_in  (dat_i[1]),
		.count_in (dat_i[7:2]),
		.count    (tim_cnt0),
		.mask     (tim_mask0),
		.irq      (time0_int)
	);

	countdown_timer u_tim1 (
		.CLK_I    (CLK_I),
		.RST_I    (RST_I),
		.tick     (tick),
		.load     (time_wr),
		.load_en  (dat_i[16]),
		.mask_in  (dat_i[17]),
		.count_in (dat_i[23:18]),
		.count    (tim_cnt1),
		.mask     (tim_mask1),
		.irq      (time1_int)
	);

	// ----------------------------------------------------------
	// read mux
	// ----------------------------------------------------------
	logic       rd_act;
	logic [5:0] rd_adr;

	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			rd_act <= 1'b0;
			rd_adr <= '0;
		end else begin
			rd_act <= rd_strobe;
			rd_adr <= adr; // sampled with the access
		end
	end

	always_comb begin
		dat_o = '0;
		if (rd_act) begin
			case (rd_adr)
				REG_WDG:  dat_o = {5'b0, wdg_cnt, wdg_en};
				REG_SFT:  dat_o = {28'b0, sft_done_r, sft_oe_n, 2'b0};
				REG_FAN0: dat_o = {6'b0, fan_rate0};
				REG_FAN1: dat_o = {6'b0, fan_rate1};
				REG_TIME: dat_o = {8'b0, tim_cnt1, tim_mask1, 1'b0,
				                   8'b0, tim_cnt0, tim_mask0, 1'b0};
				default:  dat_o = '0; // PWMC is write only
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verification/board_ctl_chk.sv
`timescale 1ns/1ps
`default_nettype none

module board_ctl_chk import board_ctl_pkg::*; (
	input wire logic        CLK_I,
	input wire logic        RST_I,
	input wire logic        stb,
	input wire logic        we,
	input wire logic [5:0]  adr,
	input wire logic [31:0] dat_i,
	input wire logic        ack,
	input wire logic        sft_shcp,
	input wire logic        sft_stcp,
	input wire logic        sft_mr_n,
	input wire logic        watch_dog
);

	logic wdg_on; // enable bit of the last accepted WDG write

	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I)
			wdg_on <= 1'b0;
		else if (stb && we && !ack && adr == REG_WDG)
			wdg_on <= dat_i[0];
	end

	// ----------------------------------------------------------
	// bus and shift pins
	// ----------------------------------------------------------
	ack_single: assert property (@(posedge CLK_I) disable iff (RST_I) ack |=> !ack)
		else $error("ack high two cycles in a row");

	clocks_apart: assert property (@(posedge CLK_I) disable iff (RST_I) !(sft_shcp && sft_stcp))
		else $error("shcp and stcp high together");

	// no store into a register being cleared
	store_in_reset: assert property (@(posedge CLK_I) disable iff (RST_I) !sft_mr_n |-> !sft_stcp)
		else $error("stcp high while mr_n low");

	wdg_gated: assert property (@(posedge CLK_I) disable iff (RST_I) watch_dog |-> wdg_on)
		else $error("watch_dog high while the watchdog is disabled");

endmodule

bind board_ctl board_ctl_chk u_chk (
	.CLK_I     (CLK_I),
	.RST_I     (RST_I),
	.stb       (stb),
	.we        (we),
	.adr       (adr),
	.dat_i     (dat_i),
	.ack       (ack),
	.sft_shcp  (sft_shcp),
	.sft_stcp  (sft_stcp),
	.sft_mr_n  (sft_mr_n),
	.watch_dog (watch_dog)
);

`default_nettype wire

// File: verification/board_ctl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module board_ctl_tb import board_ctl_pkg::*; ();

	// pwm runs dominate the run length, about 1040 cycles each
	localparam int MAX_CYCLES = 2 * (18 * 1040 + 1000);
	localparam int NUM_STEPS  = 18;

	typedef enum logic [2:0] {OP_WR, OP_RD, OP_PWM, OP_WDG, OP_SFT, OP_FAN, OP_TIM} op_e;

	typedef struct packed {
		op_e         op;
		logic [5:0]  adr;
		logic [31:0] data;
		logic [31:0] exp;
		logic [15:0] cnt; // repeat count, or windows for the timer
	} step_t;

	logic        CLK_I = 1'b0;
	logic        RST_I;
	logic        stb, we;
	logic [5:0]  adr;
	logic [31:0] dat_i, dat_o;
	logic        ack, pwm, watch_dog;
	logic        sft_shcp, sft_ds, sft_stcp, sft_mr_n, sft_oe_n;
	logic        fan_in0, fan_in1, time0_int, time1_int;

	int          errors = 0;
	int          cycles = 0;
	int          rst_cycle;
	int          ack_cycle; // cycle of the last ack
	logic [31:0] seed = 32'hdefa;
	step_t       steps [NUM_STEPS];

	// shift pin monitor
	logic        shcp_q = 1'b0;
	logic        ds_q = 1'b0;
	logic [7:0]  shift_bits = '0;
	int          shcp_rises = 0;
	int          stcp_highs = 0;
	int          mr_lows = 0;

	board_ctl dut0 (.*);

	always #5 CLK_I = ~CLK_I;

	always @(posedge CLK_I) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run exceeded %0d cycles", MAX_CYCLES);
			$display("Simulation failed");
			$finish;
		end
	end

	always @(negedge CLK_I) begin
		shcp_q <= sft_shcp;
		ds_q   <= sft_ds;
		if (sft_shcp && !shcp_q) begin
			shift_bits <= {shift_bits[6:0], ds_q}; // ds set up before the rise, MSB first
			shcp_rises <= shcp_rises + 1;
		end
		if (sft_stcp)
			stcp_highs <= stcp_highs + 1;
		if (!sft_mr_n)
			mr_lows <= mr_lows + 1;
	end

	function automatic logic [31:0] next_rand(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			errors++;
			$display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	// ----------------------------------------------------------
	// bus access, one ack expected
	// ----------------------------------------------------------
	task automatic bus_access(input logic wr, input logic [5:0] a, input logic [31:0] d,
	                          output logic [31:0] q);
		int waits;
		@(posedge CLK_I);
		stb   <= 1'b1;
		we    <= wr;
		adr   <= a;
		dat_i <= d;
		waits = 0;
		do begin
			@(negedge CLK_I);
			waits++;
		end while (!ack && waits < 8);
		if (!ack) begin
			errors++;
			$display("no ack for the access to address %0d", a);
		end
		q = dat_o;
		ack_cycle = cycles;
		@(posedge CLK_I);
		stb <= 1'b0;
		we  <= 1'b0;
		@(negedge CLK_I);
		if (ack) begin
			errors++;
			$display("ack stayed high after the access to address %0d", a);
		end
	endtask

	task automatic write_reg(input logic [5:0] a, input logic [31:0] d);
		logic [31:0] unused_q;
		bus_access(1'b1, a, d, unused_q);
	endtask

	task automatic read_reg(input logic [5:0] a, output logic [31:0] q);
		bus_access(1'b0, a, 32'h0, q);
	endtask

	// ----------------------------------------------------------
	// feature checks
	// ----------------------------------------------------------
	task automatic check_pwm(input logic [9:0] duty);
		int highs;
		write_reg(REG_PWMC, {22'h0, duty});
		highs = 0;
		repeat (1024) begin // one full counter period
			@(negedge CLK_I);
			if (pwm)
				highs++;
		end
		check_val("pwm high cycles", {22'h0, duty}, highs);
	endtask

	task automatic check_wdg(input logic [31:0] d);
		int          n, w0, k;
		logic [31:0] q;
		logic        exp_wd;
		n = int'(d[26:1]);
		write_reg(REG_WDG, d);
		w0 = ack_cycle; // count holds n from here
		read_reg(REG_WDG, q);
		check_val("wdg enable", {31'h0, d[0]}, {31'h0, q[0]});
		if (int'(q[26:1]) >= n) begin
			errors++;
			$display("watchdog count %0d read back is not below the load %0d", q[26:1], n);
		end
		k = cycles - w0;
		while (k <= n + 4) begin
			@(negedge CLK_I);
			k = cycles - w0;
			exp_wd = d[0] && (k == n - 2 || k == n - 1); // counts 2 and 1
			check_val("watch_dog", {31'h0, exp_wd}, {31'h0, watch_dog});
		end
	endtask

	task automatic run_shift(input logic [31:0] d);
		int          r0, s0, m0, polls;
		logic [31:0] q;
		r0 = shcp_rises;
		s0 = stcp_highs;
		m0 = mr_lows;
		write_reg(REG_SFT, d);
		polls = 0;
		do begin
			read_reg(REG_SFT, q);
			polls++;
		end while (!q[3] && polls < 20);
		if (!q[3]) begin
			errors++;
			$display("shift driver never reported done for command %0d", d[1:0]);
		end
		case (shift_cmd_e'(d[1:0]))
			SFT_SHIFT_BYTE: begin
				check_val("shcp rises", 32'd8, shcp_rises - r0);
				check_val("shifted byte", {24'h0, d[15:8]}, {24'h0, shift_bits});
			end
			SFT_STORE:        check_val("stcp high cycles", 32'd1, stcp_highs - s0);
			SFT_MASTER_RESET: check_val("mr_n low cycles", 32'd2, mr_lows - m0);
			default: ;
		endcase
	endtask

	task automatic check_fan(input logic [7:0] n0, input logic [7:0] n1);
		logic [31:0] q;
		while ((cycles - rst_cycle) % TICK_CYCLES != 20)
			@(negedge CLK_I);
		for (int i = 0; i < 12; i++) begin // up to 12 pulses, 4 cycles each
			@(posedge CLK_I);
			fan_in0 <= (i < int'(n0));
			fan_in1 <= (i < int'(n1));
			repeat (2) @(posedge CLK_I);
			fan_in0 <= 1'b0;
			fan_in1 <= 1'b0;
			@(posedge CLK_I);
		end
		// middle of the next window, rate latched at its start
		do @(negedge CLK_I); while ((cycles - rst_cycle) % TICK_CYCLES != 50);
		read_reg(REG_FAN0, q);
		check_val("fan0 rate", {24'h0, n0}, q);
		read_reg(REG_FAN1, q);
		check_val("fan1 rate", {24'h0, n1}, q);
	endtask

	task automatic check_timer(input logic [31:0] d, input int windows);
		int t0;
		write_reg(REG_TIME, d);
		check_val("time0_int", 32'h0, {31'h0, time0_int});
		t0 = cycles;
		while (cycles - t0 < windows * TICK_CYCLES + 10) begin
			@(negedge CLK_I);
			check_val("time1_int", 32'h0, {31'h0, time1_int}); // masked channel
		end
		check_val("time0_int", 32'h1, {31'h0, time0_int});
	endtask

	// ----------------------------------------------------------
	// stimulus table and main sequence
	// ----------------------------------------------------------
	initial begin
		logic [31:0] q;
		RST_I   = 1'b1;
		stb     = 1'b0;
		we      = 1'b0;
		adr     = '0;
		dat_i   = '0;
		fan_in0 = 1'b0;
		fan_in1 = 1'b0;

		steps[0]  = '{OP_RD,  6'd0,     32'h0,        32'h0,        16'd0};
		steps[1]  = '{OP_RD,  6'd63,    32'h0,        32'h0,        16'd0};
		steps[2]  = '{OP_RD,  REG_PWMC, 32'h0,        32'h0,        16'd0};
		steps[3]  = '{OP_PWM, REG_PWMC, 32'd0,        32'h0,        16'd0};
		steps[4]  = '{OP_PWM, REG_PWMC, 32'd1023,     32'h0,        16'd0};
		steps[5]  = '{OP_PWM, REG_PWMC, 32'h0,        32'h0,        16'd16}; // random duties
		steps[6]  = '{OP_WDG, REG_WDG,  32'd41,       32'h0,        16'd0};  // load 20, on
		steps[7]  = '{OP_WDG, REG_WDG,  32'd24,       32'h0,        16'd0};  // load 12, off
		steps[8]  = '{OP_WR,  REG_SFT,  32'h3,        32'h0,        16'd0};  // oe_n low
		steps[9]  = '{OP_RD,  REG_SFT,  32'h0,        32'h8,        16'd0};
		steps[10] = '{OP_WR,  REG_SFT,  32'h7,        32'h0,        16'd0};  // oe_n high
		steps[11] = '{OP_RD,  REG_SFT,  32'h0,        32'hc,        16'd0};
		steps[12] = '{OP_SFT, REG_SFT,  32'h0,        32'h0,        16'd1};
		steps[13] = '{OP_SFT, REG_SFT,  32'h1,        32'h0,        16'd4};  // random bytes
		steps[14] = '{OP_SFT, REG_SFT,  32'h2,        32'h0,        16'd1};
		steps[15] = '{OP_FAN, REG_FAN0, 32'h0000_0905, 32'h0,       16'd0};
		steps[16] = '{OP_TIM, REG_TIME, 32'h000b_000d, 32'h0,       16'd4};
		steps[17] = '{OP_RD,  REG_TIME, 32'h0,        32'h0002_0000, 16'd0};

		repeat (5) @(posedge CLK_I);
		RST_I <= 1'b0;
		@(negedge CLK_I);
		rst_cycle = cycles; // window phase reference
		check_val("reset outputs", {22'h0, 10'b00_0000_1100},
		          {22'h0, ack, pwm, watch_dog, sft_shcp, sft_stcp, sft_ds,
		           sft_mr_n, sft_oe_n, time0_int, time1_int});

		for (int i = 0; i < NUM_STEPS; i++) begin
			case (steps[i].op)
				OP_WR: write_reg(steps[i].adr, steps[i].data);
				OP_RD: begin
					read_reg(steps[i].adr, q);
					check_val("dat_o", steps[i].exp, q);
				end
				OP_PWM: begin
					if (steps[i].cnt == 16'd0)
						check_pwm(steps[i].data[9:0]);
					else
						repeat (steps[i].cnt) begin
							seed = next_rand(seed);
							check_pwm(seed[25:16]);
						end
				end
				OP_WDG: check_wdg(steps[i].data);
				OP_SFT: repeat (steps[i].cnt) begin
					seed = next_rand(seed);
					run_shift({16'h0, seed[23:16], 6'h0, steps[i].data[1:0]});
				end
				OP_FAN: check_fan(steps[i].data[7:0], steps[i].data[15:8]);
				OP_TIM: check_timer(steps[i].data, int'(steps[i].cnt));
				default: ;
			endcase
		end

		$display("checks done, %0d errors", errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: board_ctl.f
verilog/board_ctl_pkg.sv
verilog/shift_driver.sv
verilog/fan_tach.sv
verilog/countdown_timer.sv
verilog/board_ctl.sv
verification/board_ctl_chk.sv
verification/board_ctl_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module board_ctl_tb -f board_ctl.f -o board_ctl_sim

./obj_dir/board_ctl_sim | tee sim.log

if grep -q "Simulation passed" sim.log; then
	echo "run_sim: pass message found in sim.log"
else
	echo "run_sim: no pass message in sim.log"
	exit 1
fi
